// File: hw/cart_settings.svh
// cartridge MBC settings
// download header offsets, ROM word and cart RAM address widths
`ifndef CART_SETTINGS_SVH
`define CART_SETTINGS_SVH

// download port, byte addressed, one 16-bit word per strobe
`define CART_DL_ADDR_W      25

// header words in the image
`define CART_HDR_TYPE_ADDR  25'h146     // high byte = cartridge type
`define CART_HDR_SIZE_ADDR  25'h148     // {ram size, rom size}

// external ROM, 16-bit words, 10 bank bits + 12 offset bits
`define CART_ROM_WORD_W     22

// cart RAM, 16 banks of 8 KiB
`define CART_RAM_ADDR_W     17

`endif

// File: hw/cart_pkg.sv
// cartridge state types
// mapper kind, decoded header and the CPU written bank registers
package cart_pkg;

	////////////////////////////////////////////////////////////
	// mapper kind, decoded from header byte 0x147
	////////////////////////////////////////////////////////////
	typedef enum logic [2:0] {
		MBC_NONE = 3'd0,    // 32k flat ROM
		MBC1     = 3'd1,
		MBC2     = 3'd2,    // 512 x 4 bit internal RAM
		MBC3     = 3'd3,    // has the clock registers
		MBC5     = 3'd4     // 9 bit rom bank
	} mbc_kind_e;

	// decoded header, valid one clock after the size word
	typedef struct packed {
		mbc_kind_e   kind;      // 3 bits
		logic [8:0]  rom_mask;  // rom bank mirroring
		logic [3:0]  ram_mask;  // ram bank mirroring
	} cart_header_t;

	////////////////////////////////////////////////////////////
	// bank register state, written through 0000-7FFF
	////////////////////////////////////////////////////////////
	typedef struct packed {
		logic [8:0]  rom_bank;    // mbc1-3 use [6:0], mbc5 all 9
		logic [3:0]  ram_bank;    // 4 bits only on mbc5
		logic        mbc1_mode;   // 0 = 16/8 mode, 1 = 4/32 mode
		logic        rtc_mode;    // mbc3 clock regs mapped at A000
		logic        ram_enable;  // 0A written to 0000-1FFF
		logic        spare;       // always 0
	} bank_state_t;

endpackage

// File: hw/cpu_bus_pkg.sv
// bus types for the cartridge slot
// CPU request, image download word, 8 KiB address region
`include "cart_settings.svh"

package cpu_bus_pkg;

	// CPU side, one byte per request
	typedef struct packed {
		logic [15:0] addr;
		logic        rd;
		logic        wr;
		logic [7:0]  di;    // write data from cpu
	} cpu_req_t;

	// download side, one word per strobe
	typedef struct packed {
		logic [`CART_DL_ADDR_W-1:0] addr;   // byte address, even
		logic [15:0]                data;   // high byte = odd address
		logic                       wr;
	} dl_wr_t;

	// addr[15:13]
	typedef enum logic [2:0] {
		REG_RAM_EN   = 3'd0,    // 0000-1FFF
		REG_ROM_BANK = 3'd1,    // 2000-3FFF
		REG_RAM_BANK = 3'd2,    // 4000-5FFF
		REG_MODE     = 3'd3,    // 6000-7FFF
		VRAM_8       = 3'd4,
		CRAM_A       = 3'd5,    // A000-BFFF cart ram
		WRAM_C       = 3'd6,
		HIGH_E       = 3'd7
	} cart_region_e;

endpackage

// File: hw/cart_header_capture.sv
// cartridge header capture
// grabs type and size bytes out of the download stream and decodes mapper and masks
`timescale 1ns/1ps
`include "cart_settings.svh"

module cart_header_capture (
	input  logic                  clk_sys,
	input  logic                  reset,
	input  logic                  cart_download,
	input  cpu_bus_pkg::dl_wr_t   dl,
	output cart_pkg::cart_header_t header
);

	logic [7:0] type_byte;  // 0x147
	logic [7:0] rom_size;   // 0x148
	logic [7:0] ram_size;   // 0x149

	////////////////////////////////////////////////////////////
	// capture
	////////////////////////////////////////////////////////////
	always_ff @(posedge clk_sys) begin
		if (reset) begin
			type_byte <= 8'h00;
			rom_size  <= 8'h00;
			ram_size  <= 8'h00;
		end else if (cart_download && dl.wr) begin
			if (dl.addr == `CART_HDR_TYPE_ADDR)
				type_byte <= dl.data[15:8];         // odd byte of the word
			if (dl.addr == `CART_HDR_SIZE_ADDR)
				{ram_size, rom_size} <= dl.data;
		end
	end

	////////////////////////////////////////////////////////////
	// decode
	////////////////////////////////////////////////////////////
	always_comb begin
		case (type_byte)
			8'd1, 8'd2, 8'd3:                       header.kind = cart_pkg::MBC1;
			8'd5, 8'd6:                             header.kind = cart_pkg::MBC2;
			8'd15, 8'd16, 8'd17, 8'd18, 8'd19:      header.kind = cart_pkg::MBC3;
			8'd25, 8'd26, 8'd27, 8'd28, 8'd29, 8'd30: header.kind = cart_pkg::MBC5;
			default:                                header.kind = cart_pkg::MBC_NONE;
		endcase

		// rom size n -> 2^(n+1) banks of 16k
		case (rom_size)
			8'd1:    header.rom_mask = 9'h003;  // 64k
			8'd2:    header.rom_mask = 9'h007;
			8'd3:    header.rom_mask = 9'h00F;
			8'd4:    header.rom_mask = 9'h01F;  // 512k
			8'd5:    header.rom_mask = 9'h03F;
			8'd6:    header.rom_mask = 9'h07F;  // 2M
			8'd7:    header.rom_mask = 9'h0FF;
			8'd8:    header.rom_mask = 9'h1FF;  // 8M on mbc5 only
			default: header.rom_mask = 9'h07F;  // 0 and the odd 52-54 sizes
		endcase

		case (ram_size)
			8'd1, 8'd2: header.ram_mask = 4'h0;  // 2k or 8k in a single bank
			8'd3:       header.ram_mask = 4'h3;  // 32k
			default:    header.ram_mask = 4'hF;  // 128k
		endcase
	end

	// an X type byte would drop into the default and pass for a flat rom
	a_type_known: assert property (@(posedge clk_sys) disable iff (reset)
		!$isunknown(type_byte));

endmodule

// File: hw/mbc_bank_regs.sv
// MBC bank registers
// CPU writes to 0000-7FFF select rom bank, ram bank, mode and ram enable
`timescale 1ns/1ps

module mbc_bank_regs (
	input  logic                   clk_sys,
	input  logic                   reset,
	input  logic                   cart_download,
	input  logic                   cpu_ce,
	input  cpu_bus_pkg::cpu_req_t  cpu,
	input  cart_pkg::cart_header_t header,
	output cart_pkg::bank_state_t  banks
);

	cpu_bus_pkg::cart_region_e region;
	logic                      wr_en;
	logic                      is_mbc5;

	assign region  = cpu_bus_pkg::cart_region_e'(cpu.addr[15:13]);
	assign wr_en   = cpu.wr && cpu_ce;                  // one write per cpu cycle
	assign is_mbc5 = (header.kind == cart_pkg::MBC5);

	////////////////////////////////////////////////////////////
	// register writes
	////////////////////////////////////////////////////////////
	always_ff @(posedge clk_sys) begin
		if (reset || cart_download) begin               // new image restarts banking
			banks.rom_bank   <= 9'd1;
			banks.ram_bank   <= 4'd0;
			banks.mbc1_mode  <= 1'b0;
			banks.rtc_mode   <= 1'b0;
			banks.ram_enable <= 1'b0;
			banks.spare      <= 1'b0;
		end else if (wr_en) begin
			case (region)
				cpu_bus_pkg::REG_RAM_EN: begin
					banks.ram_enable <= (cpu.di[3:0] == 4'hA);  // any other value disables
				end

				cpu_bus_pkg::REG_ROM_BANK: begin
					if (is_mbc5) begin
						if (cpu.addr[12])
							banks.rom_bank[8] <= cpu.di[0];     // 3000-3FFF high bit
						else
							banks.rom_bank[7:0] <= cpu.di;      // 2000-2FFF, bank 0 allowed
					end else if (cpu.di[6:0] == 7'd0) begin
						banks.rom_bank <= 9'd1;                 // bank 0 maps to 1
					end else begin
						banks.rom_bank <= {2'b00, cpu.di[6:0]};
					end
				end

				cpu_bus_pkg::REG_RAM_BANK: begin
					case (header.kind)
						cart_pkg::MBC3: begin
							if (cpu.di[3]) begin
								banks.rtc_mode <= 1'b1;         // 08-0C select a clock reg
							end else begin
								banks.rtc_mode <= 1'b0;
								banks.ram_bank <= {2'b00, cpu.di[1:0]};
							end
						end
						cart_pkg::MBC5: banks.ram_bank <= cpu.di[3:0];
						default:        banks.ram_bank <= {2'b00, cpu.di[1:0]};
					endcase
				end

				cpu_bus_pkg::REG_MODE: begin
					if (header.kind == cart_pkg::MBC1)
						banks.mbc1_mode <= cpu.di[0];
				end

				default: ;  // 8000-FFFF not ours
			endcase
		end
	end

	// rom bank 0 only reachable on mbc5, header comes from the capture block
	a_rom_bank_nonzero: assert property (@(posedge clk_sys) disable iff (reset)
		!is_mbc5 |-> (banks.rom_bank != 9'd0));

endmodule

// File: hw/rom_address_map.sv
// ROM address mapper
// CPU address plus bank state to external ROM word address and byte select
`timescale 1ns/1ps
`include "cart_settings.svh"

module rom_address_map (
	input  cpu_bus_pkg::cpu_req_t       cpu,
	input  cart_pkg::cart_header_t      header,
	input  cart_pkg::bank_state_t       banks,
	output logic [`CART_ROM_WORD_W-1:0] rom_word_addr,
	output logic                        rom_byte_sel
);

	logic [8:0] sel_bank;     // effective 16k bank for 4000-7FFF
	logic [9:0] bank_field;   // 8k page, top of the word address

	////////////////////////////////////////////////////////////
	// effective bank, masked for mirroring
	////////////////////////////////////////////////////////////
	always_comb begin
		case (header.kind)
			cart_pkg::MBC1: begin
				// mode 0: ram bank bits drive rom a20-a19
				sel_bank = {2'b00, (banks.mbc1_mode ? 2'b00 : banks.ram_bank[1:0]),
					banks.rom_bank[4:0]} & header.rom_mask;
			end
			cart_pkg::MBC2, cart_pkg::MBC3: begin
				sel_bank = {2'b00, banks.rom_bank[6:0]} & header.rom_mask;
			end
			cart_pkg::MBC5: sel_bank = banks.rom_bank & header.rom_mask;
			default:        sel_bank = 9'd0;
		endcase
	end

	always_comb begin
		if (header.kind == cart_pkg::MBC_NONE) begin
			bank_field = {8'd0, cpu.addr[14:13]};           // plain 32k
		end else begin
			case (cpu.addr[15:14])
				2'b00:   bank_field = {9'd0, cpu.addr[13]};     // fixed bank 0
				2'b01:   bank_field = {sel_bank, cpu.addr[13]}; // switchable bank
				default: bank_field = 10'd0;
			endcase
		end
	end

	assign rom_word_addr = {bank_field, cpu.addr[12:1]};
	assign rom_byte_sel  = cpu.addr[0];                     // 1 = high byte of the word

endmodule

// File: hw/cart_ram.sv
// cartridge RAM
// 128 KiB banked byte RAM with the MBC specific read rules
`timescale 1ns/1ps
`include "cart_settings.svh"

module cart_ram (
	input  logic                   clk_sys,
	input  logic                   cpu_ce,
	input  cpu_bus_pkg::cpu_req_t  cpu,
	input  cart_pkg::cart_header_t header,
	input  cart_pkg::bank_state_t  banks,
	output logic [7:0]             cram_do
);

	logic [7:0] mem [0:(2**`CART_RAM_ADDR_W)-1];

	logic                        is_cram;    // A000-BFFF
	logic                        wr_en;
	logic [3:0]                  ram_bank;   // masked bank
	logic [`CART_RAM_ADDR_W-1:0] ram_addr;
	logic                        mbc2_nib;   // A000-A1FF on mbc2

	assign is_cram  = (cpu_bus_pkg::cart_region_e'(cpu.addr[15:13]) == cpu_bus_pkg::CRAM_A);
	assign wr_en    = is_cram && cpu.wr && cpu_ce;
	assign mbc2_nib = (header.kind == cart_pkg::MBC2) && (cpu.addr[15:9] == 7'b1010000);

	////////////////////////////////////////////////////////////
	// bank select
	////////////////////////////////////////////////////////////
	always_comb begin
		case (header.kind)
			cart_pkg::MBC1: begin
				// only banked in 4/32 mode
				ram_bank = banks.mbc1_mode ?
					{2'b00, banks.ram_bank[1:0] & header.ram_mask[1:0]} : 4'd0;
			end
			cart_pkg::MBC3: ram_bank = {2'b00, banks.ram_bank[1:0] & header.ram_mask[1:0]};
			cart_pkg::MBC5: ram_bank = banks.ram_bank & header.ram_mask;
			default:        ram_bank = 4'd0;  // mbc2 and no-mbc, single page
		endcase
	end

	assign ram_addr = {ram_bank, cpu.addr[12:0]};

	////////////////////////////////////////////////////////////
	// array and registered read
	////////////////////////////////////////////////////////////
	always_ff @(posedge clk_sys) begin
		if (wr_en)
			mem[ram_addr] <= cpu.di;

		// masking taken from the same cycle as the address
		if (!banks.ram_enable)
			cram_do <= 8'hFF;                         // bus floats high
		else if (mbc2_nib)
			cram_do <= {4'hF, mem[ram_addr][3:0]};    // 4 bit cells
		else if (banks.rtc_mode)
			cram_do <= 8'h00;                         // clock regs not modelled
		else
			cram_do <= mem[ram_addr];
	end

	// cpu drives one direction per access into cart ram
	a_no_rd_on_wr: assert property (@(posedge clk_sys)
		wr_en |-> !cpu.rd);

endmodule

// File: hw/gb_cart_mapper_top.sv
// cartridge MBC top level
// header capture, bank registers, ROM address map and cart RAM
`timescale 1ns/1ps
`include "cart_settings.svh"

module gb_cart_mapper_top (
	input  logic                        clk_sys,
	input  logic                        reset,
	input  logic                        cart_download,  // image streaming in
	input  logic                        cpu_ce,         // cpu clock enable
	input  cpu_bus_pkg::dl_wr_t         dl,
	input  cpu_bus_pkg::cpu_req_t       cpu,
	output logic [`CART_ROM_WORD_W-1:0] rom_word_addr,
	output logic                        rom_byte_sel,
	output logic [7:0]                  cram_do
);

	cart_pkg::cart_header_t header;   // decoded mapper and masks
	cart_pkg::bank_state_t  banks;    // cpu written bank state

	////////////////////////////////////////////////////////////
	// download side
	////////////////////////////////////////////////////////////
	cart_header_capture u_header (
		.clk_sys       (clk_sys),
		.reset         (reset),
		.cart_download (cart_download),
		.dl            (dl),
		.header        (header)
	);

	////////////////////////////////////////////////////////////
	// cpu side
	////////////////////////////////////////////////////////////
	mbc_bank_regs u_banks (
		.clk_sys       (clk_sys),
		.reset         (reset),
		.cart_download (cart_download),
		.cpu_ce        (cpu_ce),
		.cpu           (cpu),
		.header        (header),
		.banks         (banks)
	);

	rom_address_map u_rom_map (
		.cpu           (cpu),
		.header        (header),
		.banks         (banks),
		.rom_word_addr (rom_word_addr),
		.rom_byte_sel  (rom_byte_sel)
	);

	cart_ram u_cram (
		.clk_sys       (clk_sys),
		.cpu_ce        (cpu_ce),
		.cpu           (cpu),
		.header        (header),
		.banks         (banks),
		.cram_do       (cram_do)   // one clock behind the address
	);

endmodule

// File: sim/cart_vectors.svh
// cartridge mapper test vectors
// one row per clock, loaded into the testbench table before reset drops
`ifndef CART_VECTORS_SVH
`define CART_VECTORS_SVH

// columns: op, address, data, expected
//   OP_DL   download word, address is the image byte address
//   OP_WR   cpu write, data[7:0] is the byte
//   OP_ROM  rom address check, expected is the 16k bank seen at that address
//   OP_RD   cart ram read, expected is the byte one clock later
task automatic load_vectors();
	////////////////////////////////////////////////////////////
	// mbc1, 128k rom, bank mask 07
	////////////////////////////////////////////////////////////
	add_row(OP_DL,  16'h0146, 16'h0100, 16'h0000);  // type 1
	add_row(OP_DL,  16'h0148, 16'h0302, 16'h0000);  // rom size 2, ram size 3
	add_row(OP_WR,  16'h2000, 16'h001F, 16'h0000);
	add_row(OP_ROM, 16'h4000, 16'h0000, 16'h0007);  // 1F mirrors down to 7
	add_row(OP_ROM, 16'h2100, 16'h0000, 16'h0000);  // fixed bank
	add_row(OP_WR,  16'h2000, 16'h0000, 16'h0000);
	add_row(OP_ROM, 16'h5ABD, 16'h0000, 16'h0001);  // bank 0 reads as 1, odd byte

	// mbc1 mode bit, 2M rom so the upper bits show
	add_row(OP_DL,  16'h0146, 16'h0100, 16'h0000);
	add_row(OP_DL,  16'h0148, 16'h0306, 16'h0000);  // rom size 6
	add_row(OP_WR,  16'h2000, 16'h0005, 16'h0000);
	add_row(OP_WR,  16'h4000, 16'h0002, 16'h0000);  // upper bits = 2
	add_row(OP_ROM, 16'h4000, 16'h0000, 16'h0045);  // mode 0, {10,00101}
	add_row(OP_WR,  16'h6000, 16'h0001, 16'h0000);
	add_row(OP_ROM, 16'h4000, 16'h0000, 16'h0005);  // mode 1 drops them

	////////////////////////////////////////////////////////////
	// mbc5, 8M rom, 32k ram
	////////////////////////////////////////////////////////////
	add_row(OP_DL,  16'h0146, 16'h1900, 16'h0000);  // type 25
	add_row(OP_DL,  16'h0148, 16'h0308, 16'h0000);
	add_row(OP_WR,  16'h2000, 16'h0034, 16'h0000);  // low byte
	add_row(OP_WR,  16'h3000, 16'h0001, 16'h0000);  // bit 8
	add_row(OP_ROM, 16'h4000, 16'h0000, 16'h0134);
	add_row(OP_ROM, 16'h7FFF, 16'h0000, 16'h0134);  // top of the bank
	add_row(OP_RD,  16'hA123, 16'h0000, 16'h00FF);  // not enabled yet
	add_row(OP_WR,  16'h0000, 16'h000A, 16'h0000);
	add_row(OP_WR,  16'h4000, 16'h0002, 16'h0000);
	add_row(OP_WR,  16'hA123, 16'h005A, 16'h0000);  // bank 2
	add_row(OP_WR,  16'h4000, 16'h0000, 16'h0000);
	add_row(OP_WR,  16'hA123, 16'h00C3, 16'h0000);  // bank 0, same offset
	add_row(OP_RD,  16'hA123, 16'h0000, 16'h00C3);
	add_row(OP_WR,  16'h4000, 16'h0002, 16'h0000);
	add_row(OP_RD,  16'hA123, 16'h0000, 16'h005A);
	add_row(OP_WR,  16'h0000, 16'h0000, 16'h0000);  // disable again
	add_row(OP_RD,  16'hA123, 16'h0000, 16'h00FF);

	// mbc2, nibble ram
	add_row(OP_DL,  16'h0146, 16'h0500, 16'h0000);
	add_row(OP_DL,  16'h0148, 16'h0001, 16'h0000);  // rom size 1, mask 3
	add_row(OP_WR,  16'h2000, 16'h0006, 16'h0000);
	add_row(OP_ROM, 16'h4000, 16'h0000, 16'h0002);
	add_row(OP_WR,  16'h0000, 16'h000A, 16'h0000);
	add_row(OP_WR,  16'hA010, 16'h005C, 16'h0000);
	add_row(OP_RD,  16'hA010, 16'h0000, 16'h00FC);  // upper nibble reads F

	// mbc3, clock register mode
	add_row(OP_DL,  16'h0146, 16'h1300, 16'h0000);  // type 19
	add_row(OP_DL,  16'h0148, 16'h0305, 16'h0000);
	add_row(OP_WR,  16'h0000, 16'h000A, 16'h0000);
	add_row(OP_WR,  16'h4000, 16'h0001, 16'h0000);
	add_row(OP_WR,  16'hA010, 16'h0077, 16'h0000);
	add_row(OP_RD,  16'hA010, 16'h0000, 16'h0077);
	add_row(OP_WR,  16'h4000, 16'h0008, 16'h0000);  // select a clock reg
	add_row(OP_RD,  16'hA010, 16'h0000, 16'h0000);
	add_row(OP_WR,  16'h4000, 16'h0001, 16'h0000);  // back to ram bank 1
	add_row(OP_RD,  16'hA010, 16'h0000, 16'h0077);
endtask

`endif

// File: sim/tb_cart_mapper.sv
// cartridge mapper testbench
// walks the vector table through the top level and checks rom address and ram data
`timescale 1ns/1ps
`include "cart_settings.svh"

module tb_cart_mapper;

	typedef enum logic [1:0] {OP_DL, OP_WR, OP_ROM, OP_RD} op_e;

	typedef struct packed {
		op_e         op;
		logic [15:0] addr;
		logic [15:0] data;
		logic [15:0] exp_val;   // rom bank or read byte
	} vec_t;

	logic                        clk_sys;
	logic                        reset;
	logic                        cart_download;
	logic                        cpu_ce;
	cpu_bus_pkg::dl_wr_t         dl;
	cpu_bus_pkg::cpu_req_t       cpu;
	logic [`CART_ROM_WORD_W-1:0] rom_word_addr;
	logic                        rom_byte_sel;
	logic [7:0]                  cram_do;

	vec_t       vectors [$];
	int         rom_errors;
	int         ram_errors;
	int         cycle_limit;
	int         cycles;
	logic       pending;        // read issued last row
	logic [7:0] pend_exp;
	int         pend_row;

	gb_cart_mapper_top dut (
		.clk_sys       (clk_sys),
		.reset         (reset),
		.cart_download (cart_download),
		.cpu_ce        (cpu_ce),
		.dl            (dl),
		.cpu           (cpu),
		.rom_word_addr (rom_word_addr),
		.rom_byte_sel  (rom_byte_sel),
		.cram_do       (cram_do)
	);

	always #4 clk_sys = ~clk_sys;   // 125 MHz

	task automatic add_row(input op_e op, input logic [15:0] addr,
		input logic [15:0] data, input logic [15:0] exp_val);
		vec_t row;
		row.op      = op;
		row.addr    = addr;
		row.data    = data;
		row.exp_val = exp_val;
		vectors.push_back(row);
	endtask

	`include "cart_vectors.svh"

	// 16k bank on top, then a13 and the word offset
	function automatic logic [`CART_ROM_WORD_W-1:0] expected_word(input logic [8:0] bank,
		input logic [15:0] addr);
		return {bank, addr[13], addr[12:1]};
	endfunction

	task automatic drive_idle();
		cart_download = 1'b0;
		dl.wr         = 1'b0;
		cpu.wr        = 1'b0;
		cpu.rd        = 1'b0;
		cpu_ce        = 1'b0;
	endtask

	////////////////////////////////////////////////////////////
	// checks
	////////////////////////////////////////////////////////////
	task automatic check_rom(input int idx);
		logic [`CART_ROM_WORD_W-1:0] exp_word;
		exp_word = expected_word(vectors[idx].exp_val[8:0], vectors[idx].addr);
		assert (rom_word_addr === exp_word) else begin
			$display("[ERROR] rom_word_addr = %h, expected %h (row %0d)",
				rom_word_addr, exp_word, idx);
			rom_errors++;
		end
		assert (rom_byte_sel === vectors[idx].addr[0]) else begin
			$display("[ERROR] rom_byte_sel = %h, expected %h (row %0d)",
				rom_byte_sel, vectors[idx].addr[0], idx);
			rom_errors++;
		end
	endtask

	task automatic check_pending_read();
		if (pending) begin
			assert (cram_do === pend_exp) else begin
				$display("[ERROR] cram_do = %h, expected %h (row %0d)",
					cram_do, pend_exp, pend_row);
				ram_errors++;
			end
			pending = 1'b0;
		end
	endtask

	task automatic apply_row(input int idx);
		vec_t row;
		row = vectors[idx];
		drive_idle();
		case (row.op)
			OP_DL: begin
				cart_download  = 1'b1;
				dl.addr        = '0;
				dl.addr[15:0]  = row.addr;
				dl.data        = row.data;
				dl.wr          = 1'b1;
			end
			OP_WR: begin
				cpu.addr = row.addr;
				cpu.di   = row.data[7:0];
				cpu.wr   = 1'b1;
				cpu_ce   = 1'b1;
			end
			OP_ROM: begin
				cpu.addr = row.addr;
				cpu.rd   = 1'b1;
				#2;                 // settle, still before the rising edge
				check_rom(idx);
			end
			default: begin          // OP_RD, data shows after the next edge
				cpu.addr = row.addr;
				cpu.rd   = 1'b1;
				pending  = 1'b1;
				pend_exp = row.exp_val[7:0];
				pend_row = idx;
			end
		endcase
	endtask

	////////////////////////////////////////////////////////////
	// main sequence
	////////////////////////////////////////////////////////////
	initial begin
		clk_sys       = 1'b0;
		reset         = 1'b1;
		cart_download = 1'b0;
		cpu_ce        = 1'b0;
		dl            = '0;
		cpu           = '0;
		rom_errors    = 0;
		ram_errors    = 0;
		pending       = 1'b0;
		pend_exp      = 8'h00;
		pend_row      = 0;
		load_vectors();
		cycle_limit   = 20 * vectors.size() + 100;

		repeat (3) @(posedge clk_sys);
		@(negedge clk_sys);
		reset = 1'b0;

		foreach (vectors[i]) begin
			@(negedge clk_sys);
			check_pending_read();   // last row's read before driving this one
			apply_row(i);
		end
		@(negedge clk_sys);
		check_pending_read();
		drive_idle();

		$display("checks done: %0d rom address errors, %0d ram read errors",
			rom_errors, ram_errors);
		if (rom_errors + ram_errors == 0)
			$display("Done: no errors");
		else
			$display("Done: errors found");
		$finish;
	end

	// watchdog on clock cycles
	initial begin
		#1;
		for (cycles = 0; cycles < cycle_limit; cycles++)
			@(posedge clk_sys);
		$display("timeout: run did not finish within %0d clock cycles", cycle_limit);
		$display("Done: errors found");
		$finish;
	end

endmodule

// File: gb_cart_mapper.f
+incdir+hw
+incdir+sim
hw/cart_pkg.sv
hw/cpu_bus_pkg.sv
hw/cart_header_capture.sv
hw/mbc_bank_regs.sv
hw/rom_address_map.sv
hw/cart_ram.sv
hw/gb_cart_mapper_top.sv
sim/tb_cart_mapper.sv
